/* hw/pinballPkg.sv */
`default_nettype none

package pinballPkg;

	// ********************
	// Fixed point and physics
	// ********************
	localparam int fixedPointMultiplier = 64; // Position and speed scale
	localparam int gravity = 4; // Added to Y speed per frame

	// ********************
	// Screen
	// ********************
	localparam int ballInitX = 300; // Pixels
	localparam int ballInitY = 100;
	localparam int drainLineY = 470; // Ball lost below this line

	// ********************
	// Spring and flipper
	// ********************
	localparam int springMaxLevel = 15;
	localparam int springGain = 16; // Fixed-point speed per level
	localparam int flipperKickSpeed = 128;
	localparam int flipperRiseFrames = 4;

	typedef enum logic [1:0] {
		idle,
		play,
		paused,
		drained
	} gameState;

	typedef enum logic [1:0] {
		rest,
		rising,
		up
	} flipperState;

endpackage

`default_nettype wire

/* hw/ballMotion.sv */
`timescale 1ns/10ps
`default_nettype none

module ballMotion (
	input  logic               clk,
	input  logic               resetN,
	input  logic               startOfFrame,
	input  logic               pause,
	input  logic               levelReset,
	input  logic               collisionWall,
	input  logic               collisionFlipper,
	input  logic        [3:0]  hitEdgeCode, // {left, top, right, bottom}
	input  int                 flipperSpeedX,
	input  logic               springPulse,
	input  int                 springSpeedY,
	output logic signed [10:0] topLeftX,
	output logic signed [10:0] topLeftY
);

	int speedX;
	int speedY;
	int posXFixed;
	int posYFixed;

	// ********************
	// Vertical motion
	// ********************
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			speedY <= 0;
			posYFixed <= pinballPkg::ballInitY * pinballPkg::fixedPointMultiplier;
		end else if (levelReset) begin
			speedY <= 0;
			posYFixed <= pinballPkg::ballInitY * pinballPkg::fixedPointMultiplier;
		end else if (!pause) begin
			if (startOfFrame) begin
				speedY <= speedY + pinballPkg::gravity;
				posYFixed <= posYFixed + speedY; // Uses speed before gravity
			end else if (collisionWall) begin
				if (hitEdgeCode[2] && (speedY < 0)) begin
					speedY <= -speedY; // Top edge, moving up
				end else if (hitEdgeCode[0] && (speedY > 0)) begin
					speedY <= -speedY; // Bottom edge, moving down
				end
			end else if (springPulse) begin
				if (hitEdgeCode[0]) begin
					speedY <= speedY + springSpeedY;
				end
			end else if (collisionFlipper) begin
				if (hitEdgeCode[0] && (speedY > 0)) begin
					speedY <= -speedY;
				end
			end
		end
	end

	// ********************
	// Horizontal motion
	// ********************
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			speedX <= 0;
			posXFixed <= pinballPkg::ballInitX * pinballPkg::fixedPointMultiplier;
		end else if (levelReset) begin
			speedX <= 0;
			posXFixed <= pinballPkg::ballInitX * pinballPkg::fixedPointMultiplier;
		end else if (!pause) begin
			if (startOfFrame) begin
				if (posXFixed + speedX < 0) begin
					speedX <= speedX >>> 1; // Hold at left border, damp speed
				end else begin
					posXFixed <= posXFixed + speedX;
				end
			end else if (collisionWall) begin
				if (hitEdgeCode[3] && (speedX < 0)) begin
					speedX <= -speedX;
				end else if (hitEdgeCode[1] && (speedX > 0)) begin
					speedX <= -speedX;
				end
			end else if (collisionFlipper && !springPulse) begin // Spring acts on Y only
				if (hitEdgeCode[0] && (speedY > 0)) begin
					speedX <= speedX + flipperSpeedX; // Same condition as Y bounce
				end
			end
		end
	end

	// Pixel position from fixed point
	assign topLeftX = 11'(posXFixed / pinballPkg::fixedPointMultiplier);
	assign topLeftY = 11'(posYFixed / pinballPkg::fixedPointMultiplier);

endmodule

`default_nettype wire

/* hw/flipperDrive.sv */
`timescale 1ns/10ps
`default_nettype none

module flipperDrive (
	input  logic clk,
	input  logic resetN,
	input  logic startOfFrame,
	input  logic pause,
	input  logic levelReset,
	input  logic flipperKey,
	output int   flipperSpeedX
);

	pinballPkg::flipperState state;
	int riseCount;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= pinballPkg::rest;
			riseCount <= 0;
		end else if (levelReset) begin
			state <= pinballPkg::rest;
			riseCount <= 0;
		end else begin
			case (state)
				pinballPkg::rest: begin
					if (flipperKey) begin
						state <= pinballPkg::rising;
						riseCount <= 0;
					end
				end
				pinballPkg::rising: begin
					if (!flipperKey) begin
						state <= pinballPkg::rest; // Released mid-rise
					end else if (startOfFrame && !pause) begin
						if (riseCount == pinballPkg::flipperRiseFrames - 1) begin
							state <= pinballPkg::up;
						end else begin
							riseCount <= riseCount + 1;
						end
					end
				end
				pinballPkg::up: begin
					if (!flipperKey) begin
						state <= pinballPkg::rest;
					end
				end
				default: state <= pinballPkg::rest;
			endcase
		end
	end

	// Kick only while the flipper moves
	assign flipperSpeedX = (state == pinballPkg::rising) ? pinballPkg::flipperKickSpeed : 0;

endmodule

`default_nettype wire

/* hw/springLauncher.sv */
`timescale 1ns/10ps
`default_nettype none

module springLauncher (
	input  logic clk,
	input  logic resetN,
	input  logic startOfFrame,
	input  logic pause,
	input  logic levelReset,
	input  logic springKey,
	input  logic collisionSpring,
	output logic springPulse,
	output int   springSpeedY
);

	int level;
	logic springKeyPrev;
	logic keyReleased;

	assign keyReleased = springKeyPrev && !springKey;

	// ********************
	// Compression and launch
	// ********************
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			level <= 0;
			springKeyPrev <= 1'b0;
			springPulse <= 1'b0;
		end else begin
			springKeyPrev <= springKey;
			springPulse <= 1'b0;
			if (levelReset) begin
				level <= 0;
			end else if (keyReleased) begin
				level <= 0;
				springPulse <= collisionSpring; // Launch only with ball on spring
			end else if (springKey && startOfFrame && !pause) begin
				if (level < pinballPkg::springMaxLevel) begin
					level <= level + 1;
				end
			end
		end
	end

	// Upward speed, valid with the pulse
	always_ff @(posedge clk) begin
		if (keyReleased) begin
			springSpeedY <= -(level * pinballPkg::springGain);
		end
	end

endmodule

`default_nettype wire

/* hw/gameControl.sv */
`timescale 1ns/10ps
`default_nettype none

module gameControl (
	input  logic                 clk,
	input  logic                 resetN,
	input  logic                 startKey,
	input  logic                 pauseKey,
	input  logic signed [10:0]   topLeftY,
	output logic                 levelReset,
	output logic                 pause,
	output pinballPkg::gameState gameStateOut
);

	pinballPkg::gameState state;
	logic startKeyPrev;
	logic pauseKeyPrev;
	logic startRise;
	logic pauseRise;

	assign startRise = startKey && !startKeyPrev;
	assign pauseRise = pauseKey && !pauseKeyPrev;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= pinballPkg::idle;
			levelReset <= 1'b0;
			startKeyPrev <= 1'b0;
			pauseKeyPrev <= 1'b0;
		end else begin
			startKeyPrev <= startKey;
			pauseKeyPrev <= pauseKey;
			levelReset <= 1'b0;
			case (state)
				pinballPkg::idle, pinballPkg::drained: begin
					if (startRise) begin
						state <= pinballPkg::play;
						levelReset <= 1'b1;
					end
				end
				pinballPkg::play: begin
					// Ball still shows the old position during levelReset
					if (!levelReset && (topLeftY > pinballPkg::drainLineY)) begin
						state <= pinballPkg::drained;
					end else if (pauseRise) begin
						state <= pinballPkg::paused;
					end
				end
				pinballPkg::paused: begin
					if (pauseRise) begin
						state <= pinballPkg::play;
					end
				end
				default: state <= pinballPkg::idle;
			endcase
		end
	end

	assign pause = (state != pinballPkg::play); // Motion frozen outside play
	assign gameStateOut = state;

endmodule

`default_nettype wire

/* hw/pinballTop.sv */
`timescale 1ns/10ps
`default_nettype none

module pinballTop (
	input  logic                 clk,
	input  logic                 resetN,
	input  logic                 startOfFrame,
	input  logic                 collisionWall,
	input  logic                 collisionFlipper,
	input  logic                 collisionSpring,
	input  logic          [3:0]  hitEdgeCode,
	input  logic                 startKey,
	input  logic                 pauseKey,
	input  logic                 flipperKey,
	input  logic                 springKey,
	output logic signed   [10:0] topLeftX,
	output logic signed   [10:0] topLeftY,
	output pinballPkg::gameState gameStateOut
);

	logic levelReset;
	logic pause;
	logic springPulse;
	int   flipperSpeedX;
	int   springSpeedY;

	// ********************
	// Control
	// ********************
	gameControl u_gameControl (
		.clk          (clk),
		.resetN       (resetN),
		.startKey     (startKey),
		.pauseKey     (pauseKey),
		.topLeftY     (topLeftY),
		.levelReset   (levelReset),
		.pause        (pause),
		.gameStateOut (gameStateOut)
	);

	// ********************
	// Datapath
	// ********************
	flipperDrive u_flipperDrive (
		.clk           (clk),
		.resetN        (resetN),
		.startOfFrame  (startOfFrame),
		.pause         (pause),
		.levelReset    (levelReset),
		.flipperKey    (flipperKey),
		.flipperSpeedX (flipperSpeedX)
	);

	springLauncher u_springLauncher (
		.clk             (clk),
		.resetN          (resetN),
		.startOfFrame    (startOfFrame),
		.pause           (pause),
		.levelReset      (levelReset),
		.springKey       (springKey),
		.collisionSpring (collisionSpring),
		.springPulse     (springPulse),
		.springSpeedY    (springSpeedY)
	);

	ballMotion u_ballMotion (
		.clk              (clk),
		.resetN           (resetN),
		.startOfFrame     (startOfFrame),
		.pause            (pause),
		.levelReset       (levelReset),
		.collisionWall    (collisionWall),
		.collisionFlipper (collisionFlipper),
		.hitEdgeCode      (hitEdgeCode),
		.flipperSpeedX    (flipperSpeedX),
		.springPulse      (springPulse),
		.springSpeedY     (springSpeedY),
		.topLeftX         (topLeftX),
		.topLeftY         (topLeftY)
	);

endmodule

`default_nettype wire

/* dv/tbClock.sv */
`timescale 1ns/10ps
`default_nettype none

module tbClock (
	output logic clk,
	output logic resetN
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	initial begin
		resetN = 1'b0;
		repeat (4) @(posedge clk);
		resetN <= 1'b1;
	end

endmodule

`default_nettype wire

/* dv/pinballTop_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module pinballTopChk (
	input logic               clk,
	input logic               resetN,
	input logic               levelReset,
	input logic               springPulse,
	input logic               pause,
	input int                 flipperSpeedX,
	input logic               flipperKey,
	input logic signed [10:0] topLeftX,
	input logic signed [10:0] topLeftY
);

	levelResetPulse: assert property (@(posedge clk) disable iff (!resetN)
		levelReset |=> !levelReset)
		else $error("levelReset longer than one cycle");

	springPulseWidth: assert property (@(posedge clk) disable iff (!resetN)
		springPulse |=> !springPulse)
		else $error("springPulse longer than one cycle");

	// Ball frozen outside play
	pauseHoldsBall: assert property (@(posedge clk) disable iff (!resetN)
		pause |=> ($stable(topLeftX) && $stable(topLeftY)))
		else $error("Ball moved while paused");

	// Kick speed only with the key held
	flipperSpeedLegal: assert property (@(posedge clk) disable iff (!resetN)
		(flipperSpeedX == 0) ||
		((flipperSpeedX == pinballPkg::flipperKickSpeed) && $past(flipperKey)))
		else $error("flipperSpeedX out of range or without flipper key");

endmodule

bind pinballTop pinballTopChk u_chk (
	.clk           (clk),
	.resetN        (resetN),
	.levelReset    (levelReset),
	.springPulse   (springPulse),
	.pause         (pause),
	.flipperSpeedX (flipperSpeedX),
	.flipperKey    (flipperKey),
	.topLeftX      (topLeftX),
	.topLeftY      (topLeftY)
);

`default_nettype wire

/* dv/pinballTb.sv */
`timescale 1ns/10ps
`default_nettype none

module pinballTb;

	logic clk;
	logic resetN;
	logic startOfFrame;
	logic collisionWall;
	logic collisionFlipper;
	logic collisionSpring;
	logic [3:0] hitEdgeCode;
	logic startKey;
	logic pauseKey;
	logic flipperKey;
	logic springKey;
	logic signed [10:0] topLeftX;
	logic signed [10:0] topLeftY;
	pinballPkg::gameState gameStateOut;

	logic [15:0] stim [0:383]; // Six words per row
	int errors;
	int checks;
	int row;
	logic timedOut;

	tbClock u_clock (
		.clk    (clk),
		.resetN (resetN)
	);

	pinballTop u_dut (
		.clk              (clk),
		.resetN           (resetN),
		.startOfFrame     (startOfFrame),
		.collisionWall    (collisionWall),
		.collisionFlipper (collisionFlipper),
		.collisionSpring  (collisionSpring),
		.hitEdgeCode      (hitEdgeCode),
		.startKey         (startKey),
		.pauseKey         (pauseKey),
		.flipperKey       (flipperKey),
		.springKey        (springKey),
		.topLeftX         (topLeftX),
		.topLeftY         (topLeftY),
		.gameStateOut     (gameStateOut)
	);

	task automatic compareValue(input logic signed [31:0] actual,
			input logic signed [31:0] expected, input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail at %0t: row %0d %s is %0d, expected %0d",
				$time, row, what, actual, expected);
		end
	endtask

	// Let control and datapath react, then sample mid-cycle
	task automatic settle();
		repeat (3) @(posedge clk);
		@(negedge clk);
	endtask

	task automatic runFrames(input int n);
		repeat (n) begin
			@(posedge clk);
			startOfFrame <= 1'b1;
			@(posedge clk);
			startOfFrame <= 1'b0;
		end
		@(negedge clk); // New position visible one cycle after the strobe
	endtask

	task automatic setKey(input logic [15:0] sel, input logic level);
		@(posedge clk);
		case (sel)
			0: startKey <= level;
			1: pauseKey <= level;
			2: flipperKey <= level;
			default: springKey <= level;
		endcase
		settle();
	endtask

	task automatic collide(input logic [3:0] edgeCode, input logic [15:0] kind);
		@(posedge clk);
		hitEdgeCode <= edgeCode;
		collisionWall <= (kind == 1);
		collisionFlipper <= (kind == 2);
		collisionSpring <= (kind == 3); // Kind 0 clears all strobes
		settle();
	endtask

	task automatic waitState(input logic [1:0] expected, input int limit);
		int frames;
		frames = 0;
		while ((gameStateOut != expected) && !timedOut) begin
			if (frames >= limit) begin
				timedOut = 1'b1;
				errors++;
				$display("Timeout: game state did not reach %0d within %0d frames", expected, limit);
			end else begin
				runFrames(1);
				frames++;
			end
		end
	endtask

	task automatic waitReset();
		int cycles;
		cycles = 0;
		while ((resetN !== 1'b1) && !timedOut) begin
			if (cycles >= 20) begin
				timedOut = 1'b1;
				errors++;
				$display("Timeout: reset was never released");
			end else begin
				@(posedge clk);
				cycles++;
			end
		end
		@(negedge clk);
	endtask

	task automatic runRow(input int r);
		logic [15:0] action;
		logic [15:0] arg;
		logic [15:0] count;
		action = stim[r * 6];
		arg = stim[r * 6 + 1];
		count = stim[r * 6 + 2];
		case (action)
			1: runFrames(count);
			2: setKey(arg, count[0]);
			3: collide(arg[3:0], count);
			4: waitState(stim[r * 6 + 5][1:0], count);
			default: begin
				errors++;
				$display("Unknown action %0h in stimulus row %0d", action, r);
			end
		endcase
		compareValue(topLeftX, stim[r * 6 + 3], "topLeftX");
		compareValue(topLeftY, stim[r * 6 + 4], "topLeftY");
		compareValue(gameStateOut, stim[r * 6 + 5], "gameState");
	endtask

	// ********************
	// Main sequence
	// ********************
	initial begin
		startOfFrame = 1'b0;
		collisionWall = 1'b0;
		collisionFlipper = 1'b0;
		collisionSpring = 1'b0;
		hitEdgeCode = 4'b0000;
		startKey = 1'b0;
		pauseKey = 1'b0;
		flipperKey = 1'b0;
		springKey = 1'b0;
		errors = 0;
		checks = 0;
		row = 0;
		timedOut = 1'b0;
		$readmemh("dv/pinballStim.txt", stim);
		waitReset();
		while (!timedOut && (row < 64) && (stim[row * 6] != 0)) begin
			runRow(row);
			row++;
		end
		if (checks == 0) begin
			errors++;
			$display("No stimulus rows were run, check the stimulus file");
		end
		$display("Rows: %0d, checks: %0d, errors: %0d", row, checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* dv/pinballStim.txt */
// Columns (hex): action arg count expX expY expState
// Action 1 frames, 2 key (arg 0 start 1 pause 2 flipper 3 spring), 3 collide (arg edge), 4 wait, 0 end
4 0 0    12c 64 0 // Reset, idle
2 0 1    12c 64 1 // Start
2 0 0    12c 64 1
1 0 a    12c 66 1 // Free fall
1 0 a    12c 6f 1
3 1 1    12c 6f 1 // Bottom wall
3 0 0    12c 6f 1
1 0 5    12c 6a 1 // Moving up
1 0 f    12c 62 1
2 3 1    12c 62 1 // Spring held
1 0 14   12c 6e 1
3 1 3    12c 6e 1 // Ball on spring
2 3 0    12c 6e 1 // Release
3 0 0    12c 6e 1
1 0 a    12c 58 1
1 0 23   12c 3c 1
2 2 1    12c 3c 1 // Flipper rising
3 1 2    12c 3c 1 // Flipper hit
3 0 0    12c 3c 1
2 2 0    12c 3c 1
1 0 5    136 3b 1 // Two pixels per frame
2 1 1    136 3b 2 // Pause
2 1 0    136 3b 2
1 0 5    136 3b 2
2 1 1    136 3b 1 // Resume
2 1 0    136 3b 1
4 0 c8   21e 1db 3 // Fall to drain
2 0 1    12c 64 1 // Restart
2 0 0    12c 64 1
1 0 a    12c 66 1
0 0 0    0 0 0

/* verilog.f */
hw/pinballPkg.sv
hw/ballMotion.sv
hw/flipperDrive.sv
hw/springLauncher.sv
hw/gameControl.sv
hw/pinballTop.sv
dv/tbClock.sv
dv/pinballTop_chk.sv
dv/pinballTb.sv

/* Bender.yml */
package:
  name: pinball

sources:
  - files:
      - hw/pinballPkg.sv
      - hw/ballMotion.sv
      - hw/flipperDrive.sv
      - hw/springLauncher.sv
      - hw/gameControl.sv
      - hw/pinballTop.sv
  - target: simulation
    files:
      - dv/tbClock.sv
      - dv/pinballTop_chk.sv
      - dv/pinballTb.sv
